// ==== Bender.yml ====
package:
  name: spiMemory

sources:
  - files:
      - source/spiMemoryPkg.sv
      - source/inputConditioner.sv
      - source/spiShifter.sv
      - source/spiSequencer.sv
      - source/dataMemory.sv
      - source/spiMemory.sv
  - target: test
    files:
      - bench/spiMemoryBench.sv

// ==== bench/spiMemoryBench.sv ====
`timescale 1ns/1ps
`default_nettype none

module spiMemoryBench;

  localparam int sclkHalfCycles = 8;
  localparam int csGapCycles = 12;
  localparam int resetCycles = 5;
  localparam int resetReadCount = 16;
  localparam int pairCount = 8;
  localparam int randomCount = 200;
  localparam int abortCount = 8;
  localparam int transactionCount = resetReadCount + 2 * pairCount + randomCount +
                                    2 * abortCount;
  localparam real sclkPeriodNs = 640.0;
  localparam real watchdogNs = transactionCount * 18 * sclkPeriodNs + 10000.0;

  logic clk;
  logic arstN;
  logic sclk;
  logic cs;
  logic mosi;
  logic miso;
  logic misoEnable;

  integer seed = 76112;
  int errorCount = 0;

  // reference copy of the memory contents.
  spiMemoryPkg::spiData model [spiMemoryPkg::memDepth];

  spiMemory spiMemory_inst (
    .clk        (clk),
    .arstN      (arstN),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .misoEnable (misoEnable)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(watchdogNs);
    $display("watchdog timeout, transactions did not finish");
    $display("sim failed");
    $finish;
  end

  // inputs move 2 ns after the rising edge.
  task automatic stepClocks(input int count);
    repeat (count) @(posedge clk);
    #2;
  endtask

  task automatic compareData(input string signalName, input spiMemoryPkg::spiData expected,
                             input spiMemoryPkg::spiData actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, signalName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic compareBit(input string signalName, input logic expected,
                            input logic actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %b, got %b", $time, signalName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic clearModel();
    for (int i = 0; i < spiMemoryPkg::memDepth; i++) begin
      model[i] = '0;
    end
  endtask

  // one sclk period, mosi set while sclk is low, miso taken at the rising edge.
  task automatic sendBit(input logic bitValue, input logic expectEnable, output logic sampled);
    mosi = bitValue;
    stepClocks(sclkHalfCycles);
    compareBit("misoEnable", expectEnable, misoEnable);
    sampled = miso;
    sclk = 1'b1;
    stepClocks(sclkHalfCycles);
    sclk = 1'b0;
  endtask

  // sends the top bitCount bits of value, msb first.
  task automatic sendBits(input spiMemoryPkg::spiData value, input int bitCount,
                          input logic expectEnable, output spiMemoryPkg::spiData received);
    logic sampled;
    received = '0;
    for (int i = 0; i < bitCount; i++) begin
      sendBit(value[spiMemoryPkg::dataWidth-1-i], expectEnable, sampled);
      received = {received[spiMemoryPkg::dataWidth-2:0], sampled};
    end
  endtask

  task automatic endFrame();
    stepClocks(2);
    cs = 1'b1;
    stepClocks(csGapCycles);
    compareBit("misoEnable", 1'b0, misoEnable);
  endtask

  task automatic spiWrite(input spiMemoryPkg::spiAddress address,
                          input spiMemoryPkg::spiData data);
    spiMemoryPkg::spiData unused;
    cs = 1'b0;
    sendBits({address, 1'b0}, 8, 1'b0, unused);
    sendBits(data, 8, 1'b0, unused);
    endFrame();
  endtask

  task automatic spiRead(input spiMemoryPkg::spiAddress address,
                         output spiMemoryPkg::spiData data);
    spiMemoryPkg::spiData unused;
    spiMemoryPkg::spiData filler;
    filler = spiMemoryPkg::spiData'($random(seed));
    cs = 1'b0;
    sendBits({address, 1'b1}, 8, 1'b0, unused);
    // miso is driven for the whole data byte.
    sendBits(filler, 8, 1'b1, data);
    endFrame();
  endtask

  // cs goes high before the eighth data bit, so nothing may be stored.
  task automatic abortedWrite(input spiMemoryPkg::spiAddress address,
                              input spiMemoryPkg::spiData data, input int bitsSent);
    spiMemoryPkg::spiData unused;
    cs = 1'b0;
    sendBits({address, 1'b0}, 8, 1'b0, unused);
    sendBits(data, bitsSent, 1'b0, unused);
    endFrame();
  endtask

  task automatic checkRead(input spiMemoryPkg::spiAddress address);
    spiMemoryPkg::spiData data;
    spiRead(address, data);
    compareData($sformatf("readData[%0d]", address), model[address], data);
  endtask

  initial begin
    spiMemoryPkg::spiAddress address;
    spiMemoryPkg::spiData data;
    spiMemoryPkg::spiData readBack;
    int bitsSent;

    arstN = 1'b0;
    sclk = 1'b0;
    cs = 1'b1;
    mosi = 1'b0;
    clearModel();
    stepClocks(resetCycles);
    arstN = 1'b1;
    stepClocks(4);
    compareBit("misoEnable", 1'b0, misoEnable);

    // memory comes out of reset cleared.
    repeat (resetReadCount) begin
      address = spiMemoryPkg::spiAddress'($random(seed));
      checkRead(address);
    end

    repeat (pairCount) begin
      address = spiMemoryPkg::spiAddress'($random(seed));
      data = spiMemoryPkg::spiData'($random(seed));
      spiWrite(address, data);
      model[address] = data;
      spiRead(address, readBack);
      compareData($sformatf("readData[%0d]", address), data, readBack);
    end

    repeat (randomCount) begin
      address = spiMemoryPkg::spiAddress'($random(seed));
      if ($random(seed) & 1) begin
        data = spiMemoryPkg::spiData'($random(seed));
        spiWrite(address, data);
        model[address] = data;
      end else begin
        checkRead(address);
      end
    end

    repeat (abortCount) begin
      address = spiMemoryPkg::spiAddress'($random(seed));
      // flip at least one bit so a stray write would show.
      data = model[address] ^ (spiMemoryPkg::spiData'($random(seed)) | 8'h01);
      bitsSent = $random(seed) & 7;
      abortedWrite(address, data, bitsSent);
      checkRead(address);
    end

    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/dataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  addressLoad,
  input  wire                  writeEnable,
  input  spiMemoryPkg::spiData dataIn,
  output spiMemoryPkg::spiData dataOut
);

  spiMemoryPkg::spiAddress address;
  spiMemoryPkg::spiData memory [spiMemoryPkg::memDepth];

  // the address sits in the upper bits, the low bit is read/write.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      address <= '0;
    end else if (addressLoad) begin
      address <= dataIn[spiMemoryPkg::dataWidth-1 -: spiMemoryPkg::addressWidth];
    end
  end

  // storage clears to zero on reset.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < spiMemoryPkg::memDepth; i++) begin
        memory[i] <= '0;
      end
    end else if (writeEnable) begin
      memory[address] <= dataIn;
    end
  end

  assign dataOut = memory[address];

endmodule

`default_nettype wire

// ==== source/inputConditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputConditioner #(
  parameter bit resetLevel = 1'b0
) (
  input  wire  clk,
  input  wire  arstN,
  input  wire  noisy,
  output logic conditioned,
  output logic risingEdge,
  output logic fallingEdge
);

  logic syncFirst;
  logic syncSecond;
  logic [$clog2(spiMemoryPkg::debounceCycles + 1)-1:0] stableCount;
  logic accept;

  // two-flop synchronizer.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      syncFirst <= resetLevel;
      syncSecond <= resetLevel;
    end else begin
      syncFirst <= noisy;
      syncSecond <= syncFirst;
    end
  end

  // new level has held long enough.
  assign accept = (syncSecond != conditioned) &&
                  (stableCount == spiMemoryPkg::debounceCycles - 1);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stableCount <= '0;
      conditioned <= resetLevel;
      risingEdge <= 1'b0;
      fallingEdge <= 1'b0;
    end else begin
      risingEdge <= accept && syncSecond;
      fallingEdge <= accept && !syncSecond;
      if (syncSecond == conditioned || accept) begin
        stableCount <= '0;
      end else begin
        stableCount <= stableCount + 1'b1;
      end
      if (accept) begin
        conditioned <= syncSecond;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/spiMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module spiMemory (
  input  wire  clk,
  input  wire  arstN,
  input  wire  sclk,
  input  wire  cs,
  input  wire  mosi,
  output logic miso,
  output logic misoEnable
);

  logic sclkRise;
  logic sclkFall;
  logic csConditioned;
  logic mosiConditioned;
  logic addressLoad;
  logic shifterLoad;
  logic memWrite;
  spiMemoryPkg::spiData parallelOut;
  spiMemoryPkg::spiData memData;

  // only the sclk edges are needed.
  inputConditioner sclkConditioner_inst (
    .clk         (clk),
    .arstN       (arstN),
    .noisy       (sclk),
    .conditioned (),
    .risingEdge  (sclkRise),
    .fallingEdge (sclkFall)
  );

  // cs idles high, so it comes out of reset deselected.
  inputConditioner #(.resetLevel(1'b1)) csConditioner_inst (
    .clk         (clk),
    .arstN       (arstN),
    .noisy       (cs),
    .conditioned (csConditioned),
    .risingEdge  (),
    .fallingEdge ()
  );

  inputConditioner mosiConditioner_inst (
    .clk         (clk),
    .arstN       (arstN),
    .noisy       (mosi),
    .conditioned (mosiConditioned),
    .risingEdge  (),
    .fallingEdge ()
  );

  spiShifter spiShifter_inst (
    .clk          (clk),
    .arstN        (arstN),
    .shiftEnable  (sclkRise),
    .serialIn     (mosiConditioned),
    .parallelLoad (shifterLoad),
    .parallelIn   (memData),
    .parallelOut  (parallelOut),
    .misoUpdate   (sclkFall),
    .serialOut    (miso)
  );

  spiSequencer spiSequencer_inst (
    .clk           (clk),
    .arstN         (arstN),
    .csConditioned (csConditioned),
    .sclkRise      (sclkRise),
    .readWrite     (parallelOut[0]),
    .addressLoad   (addressLoad),
    .shifterLoad   (shifterLoad),
    .memWrite      (memWrite),
    .misoEnable    (misoEnable)
  );

  dataMemory dataMemory_inst (
    .clk         (clk),
    .arstN       (arstN),
    .addressLoad (addressLoad),
    .writeEnable (memWrite),
    .dataIn      (parallelOut),
    .dataOut     (memData)
  );

endmodule

`default_nettype wire

// ==== source/spiMemoryPkg.sv ====
`default_nettype none

package spiMemoryPkg;

  // address field and word width of the SPI frame.
  localparam int addressWidth = 7;
  localparam int dataWidth = 8;

  localparam int memDepth = 128;

  // clk cycles a synchronized input must hold before it is accepted.
  localparam int debounceCycles = 3;

  typedef logic [addressWidth-1:0] spiAddress;
  typedef logic [dataWidth-1:0] spiData;

  typedef enum logic [2:0] {
    idle,
    getAddress,
    gotAddress,
    readLoad,
    readShift,
    writeGet,
    writeStore,
    done
  } sequencerState;

endpackage

`default_nettype wire

// ==== source/spiSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spiSequencer (
  input  wire  clk,
  input  wire  arstN,
  input  wire  csConditioned,
  input  wire  sclkRise,
  input  wire  readWrite,
  output logic addressLoad,
  output logic shifterLoad,
  output logic memWrite,
  output logic misoEnable
);

  spiMemoryPkg::sequencerState state;
  spiMemoryPkg::sequencerState nextState;
  logic [3:0] bitCount;
  logic lastBit;
  logic counting;

  assign lastBit = (bitCount == 4'(spiMemoryPkg::dataWidth - 1));

  assign counting = (state == spiMemoryPkg::getAddress) ||
                    (state == spiMemoryPkg::readShift) ||
                    (state == spiMemoryPkg::writeGet);

  always_comb begin
    nextState = state;
    // cs high aborts from anywhere.
    if (csConditioned) begin
      nextState = spiMemoryPkg::idle;
    end else begin
      case (state)
        spiMemoryPkg::idle: begin
          nextState = spiMemoryPkg::getAddress;
        end
        spiMemoryPkg::getAddress: begin
          if (sclkRise && lastBit) begin
            nextState = spiMemoryPkg::gotAddress;
          end
        end
        spiMemoryPkg::gotAddress: begin
          nextState = readWrite ? spiMemoryPkg::readLoad : spiMemoryPkg::writeGet;
        end
        spiMemoryPkg::readLoad: begin
          nextState = spiMemoryPkg::readShift;
        end
        spiMemoryPkg::readShift: begin
          if (sclkRise && lastBit) begin
            nextState = spiMemoryPkg::done;
          end
        end
        spiMemoryPkg::writeGet: begin
          if (sclkRise && lastBit) begin
            nextState = spiMemoryPkg::writeStore;
          end
        end
        spiMemoryPkg::writeStore: begin
          nextState = spiMemoryPkg::done;
        end
        spiMemoryPkg::done: begin
          nextState = spiMemoryPkg::done;
        end
        default: begin
          nextState = spiMemoryPkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= spiMemoryPkg::idle;
      bitCount <= '0;
    end else begin
      state <= nextState;
      // counter restarts on every state change.
      if (nextState != state) begin
        bitCount <= '0;
      end else if (counting && sclkRise) begin
        bitCount <= bitCount + 1'b1;
      end
    end
  end

  // strobes are registered on the transition that leaves each state.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      addressLoad <= 1'b0;
      shifterLoad <= 1'b0;
      memWrite <= 1'b0;
      misoEnable <= 1'b0;
    end else begin
      addressLoad <= (state == spiMemoryPkg::gotAddress) &&
                     (nextState != spiMemoryPkg::idle);
      shifterLoad <= (state == spiMemoryPkg::readLoad) &&
                     (nextState == spiMemoryPkg::readShift);
      memWrite <= (state == spiMemoryPkg::writeStore) &&
                  (nextState == spiMemoryPkg::done);
      misoEnable <= (nextState == spiMemoryPkg::readShift);
    end
  end

  memWriteSingle: assert property (
    @(posedge clk) disable iff (!arstN)
    memWrite |=> !memWrite
  ) else $error("memWrite held longer than one cycle");

  misoOnlyInRead: assert property (
    @(posedge clk) disable iff (!arstN)
    misoEnable |-> (state == spiMemoryPkg::readShift)
  ) else $error("misoEnable outside readShift");

  // address latch and write must never hit the memory together.
  loadWriteExclusive: assert property (
    @(posedge clk) disable iff (!arstN)
    !(addressLoad && memWrite)
  ) else $error("addressLoad and memWrite coincide");

endmodule

`default_nettype wire

// ==== source/spiShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spiShifter (
  input  wire                  clk,
  input  wire                  arstN,
  input  wire                  shiftEnable,
  input  wire                  serialIn,
  input  wire                  parallelLoad,
  input  spiMemoryPkg::spiData parallelIn,
  output spiMemoryPkg::spiData parallelOut,
  input  wire                  misoUpdate,
  output logic                 serialOut
);

  spiMemoryPkg::spiData shiftReg;

  // load wins over shift, msb first on the wire.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      shiftReg <= '0;
    end else if (parallelLoad) begin
      shiftReg <= parallelIn;
    end else if (shiftEnable) begin
      shiftReg <= {shiftReg[spiMemoryPkg::dataWidth-2:0], serialIn};
    end
  end

  assign parallelOut = shiftReg;

  // miso only moves after falling sclk, so it is steady at the master's
  // rising-edge sample.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      serialOut <= 1'b0;
    end else if (misoUpdate) begin
      serialOut <= shiftReg[spiMemoryPkg::dataWidth-1];
    end
  end

  // the sequencer schedules the load well clear of any sclk edge.
  loadShiftExclusive: assert property (
    @(posedge clk) disable iff (!arstN)
    !(parallelLoad && shiftEnable)
  ) else $error("shifter load and shift in the same cycle");

endmodule

`default_nettype wire

// ==== spiMemory.f ====
source/spiMemoryPkg.sv
source/inputConditioner.sv
source/spiShifter.sv
source/spiSequencer.sv
source/dataMemory.sv
source/spiMemory.sv
bench/spiMemoryBench.sv
